// ==== hw/disc_pkg.sv ====
// discriminator package: channel count, sample/timestamp/delay types, gate states
package disc_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // channel and sample widths
  ////////////////////////////////////////////////////////////////////////////
  localparam int CHANNELS     = 2;
  localparam int SAMPLE_WIDTH = 16;
  localparam int TSTAMP_WIDTH = 48;

  // signed two's complement adc sample
  typedef logic signed [SAMPLE_WIDTH-1:0] sample_t;

  // running sample index since reset_state
  typedef logic [TSTAMP_WIDTH-1:0] tstamp_t;

  ////////////////////////////////////////////////////////////////////////////
  // delays and trigger selection
  ////////////////////////////////////////////////////////////////////////////
  localparam int MAX_DELAY_DEFAULT = 64;
  localparam int DELAY_WIDTH       = $clog2(MAX_DELAY_DEFAULT);

  // delay in valid samples, 0 .. MAX_DELAY_DEFAULT-1
  typedef logic [DELAY_WIDTH-1:0] delay_t;

  localparam int SRC_WIDTH = (CHANNELS > 1) ? $clog2(CHANNELS) : 1;
  typedef logic [SRC_WIDTH-1:0] src_t;

  // per-channel gate
  typedef enum logic [1:0] {
    GATE_IDLE,
    GATE_OPEN,
    GATE_HOLD
  } gate_state_t;

endpackage

// ==== hw/hysteresis_trigger.sv ====
// hysteresis trigger: sets on samples above the high threshold, clears below the low one
`timescale 1ns/10ps

module hysteresis_trigger (
  input  logic             adc_clk,
  input  logic             rst_i,
  input  logic             reset_state_i,
  input  logic             valid_i,
  input  disc_pkg::sample_t data_i,
  input  disc_pkg::sample_t low_thresh_i,
  input  disc_pkg::sample_t high_thresh_i,
  output logic             trig_o
);

  // comparator state, updated only on valid samples
  // signed compare, both operands are sample_t
  always_ff @(posedge adc_clk) begin
    if (rst_i || reset_state_i) begin
      trig_o <= 1'b0;
    end else if (valid_i) begin
      if (data_i > high_thresh_i) begin
        trig_o <= 1'b1;
      end else if (data_i < low_thresh_i) begin
        trig_o <= 1'b0;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // checks
  ////////////////////////////////////////////////////////////////////////////

  // gate_fsm samples trig_o only at valids, so a change between
  // valids would slip a trigger past the keep window
  a_trig_changes_on_valid : assert property (
    @(posedge adc_clk) disable iff (rst_i)
    $changed(trig_o) |-> ($past(valid_i) || $past(reset_state_i))
  ) else $error("trig_o changed without a preceding valid");

endmodule

// ==== hw/sample_delay_line.sv ====
// sample delay line: shift register advanced on valid with a tap set by start_delay
`timescale 1ns/10ps

module sample_delay_line #(
  parameter int MAX_DELAY = disc_pkg::MAX_DELAY_DEFAULT
) (
  input  logic             adc_clk,
  input  logic             rst_i,
  input  logic             valid_i,
  input  disc_pkg::sample_t data_i,
  input  disc_pkg::delay_t  start_delay_i,
  output disc_pkg::sample_t dly_data_o,
  output logic             dly_valid_o
);

  import disc_pkg::*;

  // tap 0 is the incoming sample itself, taps 1 .. MAX_DELAY-1 are stored
  sample_t sr [1:MAX_DELAY-1];

  ////////////////////////////////////////////////////////////////////////////
  // storage
  ////////////////////////////////////////////////////////////////////////////

  // payload only, advances once per valid sample
  always_ff @(posedge adc_clk) begin
    if (valid_i) begin
      sr[1] <= data_i;
      for (int i = 2; i < MAX_DELAY; i++) begin
        sr[i] <= sr[i-1];
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // tap select
  ////////////////////////////////////////////////////////////////////////////

  // zero delay passes the current sample straight on
  always_comb begin
    if (start_delay_i == '0) begin
      dly_data_o = data_i;
    end else begin
      dly_data_o = sr[start_delay_i];
    end
  end

  // the leaving sample goes out in the same cycle as the entering one
  assign dly_valid_o = valid_i;

  // configuration from the top must fit the depth chosen there
  a_delay_in_range : assert property (
    @(posedge adc_clk) disable iff (rst_i)
    valid_i |-> (int'(start_delay_i) < MAX_DELAY)
  ) else $error("start_delay_i %0d exceeds delay line depth %0d", start_delay_i, MAX_DELAY);

endmodule

// ==== hw/hold_timer.sv ====
// hold timer: counts down valid samples after a trigger falls, expired at zero
`timescale 1ns/10ps

module hold_timer (
  input  logic                                 adc_clk,
  input  logic                                 rst_i,
  input  logic                                 valid_i,
  input  logic                                 load_i,
  input  logic [$bits(disc_pkg::delay_t):0]    hold_len_i,
  output logic                                 expired_o
);

  import disc_pkg::*;

  // one extra bit, hold length is start_delay + stop_delay
  logic [$bits(delay_t):0] count;

  // a load arriving with a valid counts that valid as the first
  // held sample, so the count starts one lower
  always_ff @(posedge adc_clk) begin
    if (rst_i) begin
      count <= '0;
    end else if (load_i && valid_i) begin
      if (hold_len_i != '0) begin
        count <= hold_len_i - 1'b1;
      end else begin
        count <= '0;
      end
    end else if (load_i) begin
      count <= hold_len_i;
    end else if (valid_i && (count != '0)) begin
      count <= count - 1'b1;
    end
  end

  assign expired_o = (count == '0);

endmodule

// ==== hw/gate_fsm.sv ====
// gate FSM: picks the trigger source and decides which leaving samples are kept
`timescale 1ns/10ps

module gate_fsm #(
  parameter int CHANNELS = disc_pkg::CHANNELS
) (
  input  logic                adc_clk,
  input  logic                rst_i,
  input  logic                reset_state_i,
  input  logic                valid_i,
  input  logic [CHANNELS-1:0] trig_vec_i,
  input  disc_pkg::src_t      trig_src_i,
  input  logic                disable_i,
  input  disc_pkg::delay_t    start_delay_i,
  input  disc_pkg::delay_t    stop_delay_i,
  input  logic                expired_i,
  output logic                load_o,
  output logic                keep_o,
  output logic                open_o
);

  import disc_pkg::*;

  gate_state_t state;
  gate_state_t state_next;
  logic        trig_sel;
  logic        hold_en;
  logic        keep_win;

  // trigger seen at the current valid, i.e. state after all earlier samples
  assign trig_sel = trig_vec_i[trig_src_i];

  // window longer than one sample needs the hold phase
  assign hold_en = (start_delay_i != '0) || (stop_delay_i != '0);

  ////////////////////////////////////////////////////////////////////////////
  // state register, advances on valid only
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge adc_clk) begin
    if (rst_i || reset_state_i) begin
      state <= GATE_IDLE;
    end else if (valid_i) begin
      state <= state_next;
    end
  end

  always_comb begin
    state_next = state;
    load_o     = 1'b0;
    case (state)
      GATE_IDLE: begin
        if (trig_sel) begin
          state_next = GATE_OPEN;
        end
      end
      GATE_OPEN: begin
        if (!trig_sel) begin
          if (hold_en) begin
            state_next = GATE_HOLD;
            load_o     = valid_i;
          end else begin
            state_next = GATE_IDLE;
          end
        end
      end
      GATE_HOLD: begin
        if (trig_sel) begin
          state_next = GATE_OPEN;
        end else if (expired_i) begin
          state_next = GATE_IDLE;
        end
      end
      default: state_next = GATE_IDLE;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // keep / open decode
  ////////////////////////////////////////////////////////////////////////////

  // kept when the trigger was high at this valid or within the
  // last start_delay + stop_delay valids
  always_comb begin
    case (state)
      GATE_OPEN: keep_win = trig_sel || hold_en;
      GATE_HOLD: keep_win = trig_sel || !expired_i;
      default:   keep_win = trig_sel;
    endcase
  end

  assign keep_o = disable_i || keep_win;

  // first kept sample after an idle stretch starts a new segment
  assign open_o = !disable_i && (state == GATE_IDLE) && trig_sel;

endmodule

// ==== hw/output_gate.sv ====
// output gate: registers kept samples and emits the segment timestamp
`timescale 1ns/10ps

module output_gate (
  input  logic              adc_clk,
  input  logic              rst_i,
  input  logic              reset_state_i,
  input  logic              dly_valid_i,
  input  disc_pkg::sample_t  dly_data_i,
  input  logic              in_valid_i,
  input  disc_pkg::delay_t   start_delay_i,
  input  logic              keep_i,
  input  logic              open_i,
  output disc_pkg::sample_t  data_o,
  output logic              valid_o,
  output disc_pkg::tstamp_t  tstamp_o,
  output logic              tstamp_valid_o
);

  import disc_pkg::*;

  // index of the sample entering at the current valid
  tstamp_t sample_index;
  tstamp_t leave_index;

  // leaving sample is start_delay valids older than the entering one
  assign leave_index = sample_index - tstamp_t'(start_delay_i);

  ////////////////////////////////////////////////////////////////////////////
  // control
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge adc_clk) begin
    if (rst_i || reset_state_i) begin
      sample_index   <= '0;
      valid_o        <= 1'b0;
      tstamp_valid_o <= 1'b0;
    end else begin
      if (in_valid_i) begin
        sample_index <= sample_index + 1'b1;
      end
      valid_o        <= dly_valid_i && keep_i;
      tstamp_valid_o <= dly_valid_i && keep_i && open_i;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // payload
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge adc_clk) begin
    if (dly_valid_i) begin
      data_o   <= dly_data_i;
      tstamp_o <= leave_index;
    end
  end

  // a timestamp always belongs to a sample that actually leaves
  a_tstamp_with_sample : assert property (
    @(posedge adc_clk) disable iff (rst_i)
    tstamp_valid_o |-> valid_o
  ) else $error("tstamp_valid_o without valid_o");

endmodule

// ==== hw/sample_discriminator.sv ====
// sample discriminator top: per-channel trigger, delay, gate and output slices
`timescale 1ns/10ps

module sample_discriminator #(
  parameter int CHANNELS  = disc_pkg::CHANNELS,
  parameter int MAX_DELAY = disc_pkg::MAX_DELAY_DEFAULT
) (
  input  logic                                adc_clk,
  input  logic                                rst_i,
  input  logic                                reset_state_i,
  // adc stream in
  input  disc_pkg::sample_t [CHANNELS-1:0]     data_i,
  input  logic              [CHANNELS-1:0]     valid_i,
  // configuration, static while reset_state_i is low
  input  disc_pkg::sample_t [CHANNELS-1:0]     low_thresh_i,
  input  disc_pkg::sample_t [CHANNELS-1:0]     high_thresh_i,
  input  disc_pkg::delay_t  [CHANNELS-1:0]     start_delay_i,
  input  disc_pkg::delay_t  [CHANNELS-1:0]     stop_delay_i,
  input  disc_pkg::src_t    [CHANNELS-1:0]     trig_src_i,
  input  logic              [CHANNELS-1:0]     disable_i,
  // kept samples and segment timestamps out
  output disc_pkg::sample_t [CHANNELS-1:0]     data_o,
  output logic              [CHANNELS-1:0]     valid_o,
  output disc_pkg::tstamp_t [CHANNELS-1:0]     tstamp_o,
  output logic              [CHANNELS-1:0]     tstamp_valid_o
);

  import disc_pkg::*;

  // every gate sees every channel's trigger
  logic [CHANNELS-1:0] trig_vec;

  // timer starts out expired after either reset
  logic timer_rst;
  assign timer_rst = rst_i || reset_state_i;

  for (genvar ch = 0; ch < CHANNELS; ch++) begin : g_chan

    sample_t                 dly_data;
    logic                    dly_valid;
    logic                    keep;
    logic                    open;
    logic                    load;
    logic                    expired;
    logic [$bits(delay_t):0] hold_len;

    // window after the trigger falls, in valid samples
    assign hold_len = {1'b0, start_delay_i[ch]} + {1'b0, stop_delay_i[ch]};

    hysteresis_trigger u_trigger (
      .adc_clk       (adc_clk),
      .rst_i         (rst_i),
      .reset_state_i (reset_state_i),
      .valid_i       (valid_i[ch]),
      .data_i        (data_i[ch]),
      .low_thresh_i  (low_thresh_i[ch]),
      .high_thresh_i (high_thresh_i[ch]),
      .trig_o        (trig_vec[ch])
    );

    sample_delay_line #(
      .MAX_DELAY (MAX_DELAY)
    ) u_delay (
      .adc_clk       (adc_clk),
      .rst_i         (rst_i),
      .valid_i       (valid_i[ch]),
      .data_i        (data_i[ch]),
      .start_delay_i (start_delay_i[ch]),
      .dly_data_o    (dly_data),
      .dly_valid_o   (dly_valid)
    );

    hold_timer u_timer (
      .adc_clk    (adc_clk),
      .rst_i      (timer_rst),
      .valid_i    (valid_i[ch]),
      .load_i     (load),
      .hold_len_i (hold_len),
      .expired_o  (expired)
    );

    gate_fsm #(
      .CHANNELS (CHANNELS)
    ) u_gate (
      .adc_clk       (adc_clk),
      .rst_i         (rst_i),
      .reset_state_i (reset_state_i),
      .valid_i       (valid_i[ch]),
      .trig_vec_i    (trig_vec),
      .trig_src_i    (trig_src_i[ch]),
      .disable_i     (disable_i[ch]),
      .start_delay_i (start_delay_i[ch]),
      .stop_delay_i  (stop_delay_i[ch]),
      .expired_i     (expired),
      .load_o        (load),
      .keep_o        (keep),
      .open_o        (open)
    );

    output_gate u_out (
      .adc_clk        (adc_clk),
      .rst_i          (rst_i),
      .reset_state_i  (reset_state_i),
      .dly_valid_i    (dly_valid),
      .dly_data_i     (dly_data),
      .in_valid_i     (valid_i[ch]),
      .start_delay_i  (start_delay_i[ch]),
      .keep_i         (keep),
      .open_i         (open),
      .data_o         (data_o[ch]),
      .valid_o        (valid_o[ch]),
      .tstamp_o       (tstamp_o[ch]),
      .tstamp_valid_o (tstamp_valid_o[ch])
    );

  end

endmodule

// ==== verif/disc_checks.svh ====
// discriminator checks: concurrent assertions on the DUT outputs against the model
`ifndef DISC_CHECKS_SVH
`define DISC_CHECKS_SVH

  int unsigned mismatch_count = 0;
  int unsigned other_errors   = 0;

  ////////////////////////////////////////////////////////////////////////////
  // per-channel output checks, sampled at the rising edge
  ////////////////////////////////////////////////////////////////////////////
  for (genvar c = 0; c < CHANNELS; c++) begin : g_chk

    // trigger state, also covers clearing by reset_state
    a_trig : assert property (
      @(posedge adc_clk) disable iff (rst_i || !chk_en)
      u_sample_discriminator.trig_vec[c] == cur_trig[c]
    ) else begin
      mismatch_count++;
      $display("MISMATCH ch%0d trig: got %h expected %h", c,
               $sampled(u_sample_discriminator.trig_vec[c]), $sampled(cur_trig[c]));
    end

    a_valid : assert property (
      @(posedge adc_clk) disable iff (rst_i || !chk_en)
      valid_o[c] == cur_valid[c]
    ) else begin
      mismatch_count++;
      $display("MISMATCH ch%0d valid_o: got %h expected %h", c,
               $sampled(valid_o[c]), $sampled(cur_valid[c]));
    end

    // data unknown for taps older than the first sample after rst
    a_data : assert property (
      @(posedge adc_clk) disable iff (rst_i || !chk_en)
      (cur_valid[c] && cur_data_ok[c]) |-> (data_o[c] == cur_data[c])
    ) else begin
      mismatch_count++;
      $display("MISMATCH ch%0d data_o: got %h expected %h", c,
               $sampled(data_o[c]), $sampled(cur_data[c]));
    end

    a_tstamp_valid : assert property (
      @(posedge adc_clk) disable iff (rst_i || !chk_en)
      tstamp_valid_o[c] == cur_tsv[c]
    ) else begin
      mismatch_count++;
      $display("MISMATCH ch%0d tstamp_valid_o: got %h expected %h", c,
               $sampled(tstamp_valid_o[c]), $sampled(cur_tsv[c]));
    end

    a_tstamp : assert property (
      @(posedge adc_clk) disable iff (rst_i || !chk_en)
      cur_tsv[c] |-> (tstamp_o[c] == cur_ts[c])
    ) else begin
      mismatch_count++;
      $display("MISMATCH ch%0d tstamp_o: got %h expected %h", c,
               $sampled(tstamp_o[c]), $sampled(cur_ts[c]));
    end

  end

`endif

// ==== verif/sample_discriminator_tb.sv ====
// sample discriminator testbench: random adc phases, reference model and timeout
`timescale 1ns/10ps

module sample_discriminator_tb;

  import disc_pkg::*;

  localparam int RING         = 128;
  localparam int NO_HIGH      = 1000;
  localparam int RESET_CYCLES = 16;
  localparam int NUM_PHASES   = 6;
  localparam int PHASE_CYCLES = 1600;
  localparam int CFG_CYCLES   = 3;
  localparam int DRAIN_CYCLES = 8;
  // twice the scheduled length of all phases
  localparam int CYCLE_LIMIT  =
    2 * (RESET_CYCLES + NUM_PHASES * (PHASE_CYCLES + CFG_CYCLES) + DRAIN_CYCLES);

  logic                         adc_clk = 1'b0;
  logic                         rst_i = 1'b1;
  logic                         reset_state_i = 1'b0;
  sample_t [CHANNELS-1:0]       data_i = '0;
  logic    [CHANNELS-1:0]       valid_i = '0;
  sample_t [CHANNELS-1:0]       low_thresh_i = '0;
  sample_t [CHANNELS-1:0]       high_thresh_i = '0;
  delay_t  [CHANNELS-1:0]       start_delay_i = '0;
  delay_t  [CHANNELS-1:0]       stop_delay_i = '0;
  src_t    [CHANNELS-1:0]       trig_src_i = '0;
  logic    [CHANNELS-1:0]       disable_i = '0;
  sample_t [CHANNELS-1:0]       data_o;
  logic    [CHANNELS-1:0]       valid_o;
  tstamp_t [CHANNELS-1:0]       tstamp_o;
  logic    [CHANNELS-1:0]       tstamp_valid_o;

  // model expectations, nxt for the coming edge and cur for the outputs now visible
  logic    [CHANNELS-1:0] nxt_valid = '0;
  logic    [CHANNELS-1:0] cur_valid = '0;
  logic    [CHANNELS-1:0] nxt_tsv = '0;
  logic    [CHANNELS-1:0] cur_tsv = '0;
  logic    [CHANNELS-1:0] nxt_trig = '0;
  logic    [CHANNELS-1:0] cur_trig = '0;
  logic    [CHANNELS-1:0] nxt_data_ok = '0;
  logic    [CHANNELS-1:0] cur_data_ok = '0;
  sample_t [CHANNELS-1:0] nxt_data = '0;
  sample_t [CHANNELS-1:0] cur_data = '0;
  tstamp_t [CHANNELS-1:0] nxt_ts = '0;
  tstamp_t [CHANNELS-1:0] cur_ts = '0;

  // model state
  logic    hyst [CHANNELS];
  int      since_high [CHANNELS];
  logic    prev_win [CHANNELS];
  tstamp_t idx [CHANNELS];
  sample_t ring [CHANNELS][RING];
  longint  gcount = 0;

  logic        chk_en = 1'b0;
  int          seed = 32'hf9a98405;
  int unsigned cycle_count = 0;
  int unsigned kept_count = 0;
  int unsigned tstamp_count = 0;

  sample_discriminator #(
    .CHANNELS  (CHANNELS),
    .MAX_DELAY (MAX_DELAY_DEFAULT)
  ) u_sample_discriminator (
    .adc_clk        (adc_clk),
    .rst_i          (rst_i),
    .reset_state_i  (reset_state_i),
    .data_i         (data_i),
    .valid_i        (valid_i),
    .low_thresh_i   (low_thresh_i),
    .high_thresh_i  (high_thresh_i),
    .start_delay_i  (start_delay_i),
    .stop_delay_i   (stop_delay_i),
    .trig_src_i     (trig_src_i),
    .disable_i      (disable_i),
    .data_o         (data_o),
    .valid_o        (valid_o),
    .tstamp_o       (tstamp_o),
    .tstamp_valid_o (tstamp_valid_o)
  );

  `include "disc_checks.svh"

  always #5 adc_clk = ~adc_clk;

  always @(posedge adc_clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= CYCLE_LIMIT) begin
      $display("timeout after %0d cycles, stimulus did not finish", cycle_count);
      $display("FAIL: see errors above");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // reference model
  ////////////////////////////////////////////////////////////////////////////

  // sample n kept when the selected trigger, as seen at a valid,
  // was high at any of samples n-stop .. n+start
  task automatic step_model(input logic rs, input logic v);
    logic    tsel [CHANNELS];
    logic    win;
    int      dly;
    int      hold;
    sample_t s;
    sample_t lo;
    sample_t hi;
    if (rs) begin
      for (int c = 0; c < CHANNELS; c++) begin
        hyst[c]       = 1'b0;
        since_high[c] = NO_HIGH;
        prev_win[c]   = 1'b0;
        idx[c]        = '0;
      end
      nxt_valid = '0;
      nxt_tsv   = '0;
      nxt_trig  = '0;
    end else if (v) begin
      for (int c = 0; c < CHANNELS; c++) begin
        tsel[c] = hyst[int'(trig_src_i[c])];
      end
      for (int c = 0; c < CHANNELS; c++) begin
        dly  = int'(start_delay_i[c]);
        hold = dly + int'(stop_delay_i[c]);
        s    = data_i[c];
        lo   = low_thresh_i[c];
        hi   = high_thresh_i[c];
        ring[c][gcount % RING] = s;
        if (tsel[c]) begin
          since_high[c] = 0;
        end else if (since_high[c] < NO_HIGH) begin
          since_high[c]++;
        end
        win            = (since_high[c] <= hold);
        nxt_valid[c]   = disable_i[c] || win;
        nxt_tsv[c]     = !disable_i[c] && win && !prev_win[c];
        prev_win[c]    = win;
        nxt_ts[c]      = idx[c] - tstamp_t'(dly);
        nxt_data_ok[c] = (gcount >= dly);
        if (gcount >= dly) begin
          nxt_data[c] = ring[c][(gcount - dly) % RING];
        end
        idx[c] = idx[c] + 1'b1;
        // hysteresis rule
        if (s > hi) begin
          hyst[c] = 1'b1;
        end else if (s < lo) begin
          hyst[c] = 1'b0;
        end
        nxt_trig[c] = hyst[c];
        if (nxt_valid[c]) kept_count++;
        if (nxt_tsv[c]) tstamp_count++;
      end
      gcount++;
    end else begin
      nxt_valid = '0;
      nxt_tsv   = '0;
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////////////////////////////////////////

  // one falling edge: expose last predictions, drive inputs, predict
  task automatic drive_cycle(input logic rs, input logic v, input int shift);
    logic [31:0] r;
    @(negedge adc_clk);
    cur_valid   = nxt_valid;
    cur_tsv     = nxt_tsv;
    cur_trig    = nxt_trig;
    cur_data_ok = nxt_data_ok;
    cur_data    = nxt_data;
    cur_ts      = nxt_ts;
    reset_state_i = rs;
    valid_i       = {CHANNELS{v}};
    for (int c = 0; c < CHANNELS; c++) begin
      r = $random(seed);
      data_i[c] = sample_t'($signed(r[15:0]) >>> shift);
    end
    step_model(rs, v);
  endtask

  task automatic load_config(input int ph);
    low_thresh_i[0]  = -16'sd1000;
    high_thresh_i[0] = 16'sd1000;
    low_thresh_i[1]  = -16'sd300;
    high_thresh_i[1] = 16'sd1500;
    trig_src_i[0]    = src_t'(0);
    trig_src_i[1]    = src_t'(1);
    disable_i        = '0;
    case (ph)
      0: begin
        start_delay_i = {6'd0, 6'd0};
        stop_delay_i  = {6'd0, 6'd0};
      end
      1: begin
        start_delay_i = {6'd2, 6'd5};
        stop_delay_i  = {6'd9, 6'd3};
      end
      2: begin
        start_delay_i = {6'd12, 6'd0};
        stop_delay_i  = {6'd0, 6'd10};
      end
      // each channel follows the other one's trigger
      3: begin
        trig_src_i[0] = src_t'(1);
        trig_src_i[1] = src_t'(0);
        start_delay_i = {6'd1, 6'd7};
        stop_delay_i  = {6'd6, 6'd2};
      end
      4: begin
        disable_i     = 2'b01;
        start_delay_i = {6'd63, 6'd4};
        stop_delay_i  = {6'd63, 6'd4};
      end
      default: begin
        disable_i     = 2'b10;
        trig_src_i[0] = src_t'(1);
        start_delay_i = {6'd3, 6'd20};
        stop_delay_i  = {6'd3, 6'd0};
      end
    endcase
  endtask

  // decimation 0 picks a random ratio of 1 to 4 per sample
  task automatic run_phase(input int ph, input int decim_mode, input int shift);
    int decim;
    int dcnt;
    // configuration moves only while reset_state is high
    drive_cycle(1'b1, 1'b0, shift);
    load_config(ph);
    for (int i = 1; i < CFG_CYCLES; i++) begin
      drive_cycle(1'b1, 1'b0, shift);
    end
    decim = (decim_mode == 0) ? 1 : decim_mode;
    dcnt  = 0;
    for (int i = 0; i < PHASE_CYCLES; i++) begin
      drive_cycle(1'b0, dcnt == 0, shift);
      dcnt++;
      if (dcnt >= decim) begin
        dcnt = 0;
        if (decim_mode == 0) begin
          decim = 1 + ($unsigned($random(seed)) % 4);
        end
      end
    end
  endtask

  initial begin
    for (int c = 0; c < CHANNELS; c++) begin
      hyst[c]       = 1'b0;
      since_high[c] = NO_HIGH;
      prev_win[c]   = 1'b0;
      idx[c]        = '0;
    end
    repeat (RESET_CYCLES) @(negedge adc_clk);
    rst_i  = 1'b0;
    chk_en = 1'b1;

    run_phase(0, 1, 4);
    run_phase(1, 2, 4);
    run_phase(2, 3, 3);
    run_phase(3, 4, 4);
    run_phase(4, 1, 5);
    run_phase(5, 0, 4);
    for (int i = 0; i < DRAIN_CYCLES; i++) begin
      drive_cycle(1'b0, 1'b0, 4);
    end

    if (tstamp_count == 0) begin
      other_errors++;
      $display("no segment timestamps were expected, stimulus never opened a segment");
    end
    $display("errors: %0d mismatches, %0d other; %0d kept samples, %0d timestamps checked",
             mismatch_count, other_errors, kept_count, tstamp_count);
    if (mismatch_count == 0 && other_errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

// ==== sim.f ====
+incdir+verif
hw/disc_pkg.sv
hw/hysteresis_trigger.sv
hw/sample_delay_line.sv
hw/hold_timer.sv
hw/gate_fsm.sv
hw/output_gate.sv
hw/sample_discriminator.sv
verif/sample_discriminator_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the testbench with Verilator, run it and search the log for the pass line

rm -rf obj_dir sim.log

verilator --binary --timing --assert \
  --top-module sample_discriminator_tb \
  -f sim.f -o tb_sim \
  && ./obj_dir/tb_sim > sim.log 2>&1

if [ -f sim.log ]; then
  cat sim.log
fi

grep -q "^PASS: all tests$" sim.log \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
